//--- rtl/cache_pkg.sv
package cache_pkg;

   // front-end word address, select bit included
   localparam int ADDR_W     = 12;
   localparam int DATA_W     = 32;
   localparam int NBYTES     = 4;

   // direct-mapped geometry: 16 lines of 4 words
   localparam int TAG_W      = 5;
   localparam int INDEX_W    = 4;
   localparam int OFFSET_W   = 2;
   localparam int LINE_W     = 128;
   localparam int MEM_ADDR_W = 11;

   localparam int CTRL_REG_W = 3;

   // counter registers share index order with the event pulses
   localparam logic [CTRL_REG_W-1:0] REG_READ_HIT   = 3'd0;
   localparam logic [CTRL_REG_W-1:0] REG_READ_MISS  = 3'd1;
   localparam logic [CTRL_REG_W-1:0] REG_WRITE_HIT  = 3'd2;
   localparam logic [CTRL_REG_W-1:0] REG_WRITE_MISS = 3'd3;
   localparam logic [CTRL_REG_W-1:0] REG_WRITE_IDLE = 3'd4;
   localparam logic [CTRL_REG_W-1:0] REG_CNT_CLEAR  = 3'd5;
   localparam logic [CTRL_REG_W-1:0] REG_INVALIDATE = 3'd6;

   // select bit clear: cache data, set: control registers
   typedef union packed {
      struct packed {
         logic                sel;
         logic [TAG_W-1:0]    tag;
         logic [INDEX_W-1:0]  index;
         logic [OFFSET_W-1:0] offset;
      } data;
      struct packed {
         logic                         sel;
         logic [ADDR_W-CTRL_REG_W-2:0] pad;
         logic [CTRL_REG_W-1:0]        reg_idx;
      } ctrl;
   } cache_addr_u;

endpackage

//--- rtl/cache_front_end.sv
`timescale 1ns/1ps

module cache_front_end (
   input  logic                              clk,
   input  logic                              arst_n,
   input  logic                              req,
   input  cache_pkg::cache_addr_u            addr,
   input  logic [cache_pkg::DATA_W-1:0]      wdata,
   input  logic [cache_pkg::NBYTES-1:0]      wstrb,
   input  logic                              data_ack,
   input  logic [cache_pkg::DATA_W-1:0]      data_rdata,
   input  logic                              ctrl_ack,
   input  logic [cache_pkg::DATA_W-1:0]      ctrl_rdata,
   output logic                              ack,
   output logic [cache_pkg::DATA_W-1:0]      rdata,
   output logic                              data_req,
   output cache_pkg::cache_addr_u            data_addr,
   output logic                              ctrl_req,
   output logic [cache_pkg::CTRL_REG_W-1:0]  ctrl_reg,
   output logic [cache_pkg::DATA_W-1:0]      req_wdata,
   output logic [cache_pkg::NBYTES-1:0]      req_wstrb
);
   import cache_pkg::*;

   logic busy;

   // same stored word, read through the control view
   assign ctrl_reg = data_addr.ctrl.reg_idx;
   assign ack      = data_ack | ctrl_ack;
   assign rdata    = ctrl_ack ? ctrl_rdata : data_rdata;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         data_req <= 1'b0;
         ctrl_req <= 1'b0;
         busy     <= 1'b0;
      end else begin
         data_req <= req & ~addr.data.sel;
         ctrl_req <= req & addr.ctrl.sel;
         if (req)
            busy <= 1'b1;
         else if (ack)
            busy <= 1'b0;
      end
   end

   // request fields held until the next req
   always_ff @(posedge clk) begin
      if (req) begin
         data_addr <= addr;
         req_wdata <= wdata;
         req_wstrb <= wstrb;
      end
   end

   // only one access in flight, next req no earlier than after ack
   a_one_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
      req |-> !busy);

endmodule

//--- rtl/cache_memory.sv
`timescale 1ns/1ps

module cache_memory (
   input  logic                                             clk,
   input  logic                                             arst_n,
   input  logic                                             data_req,
   input  cache_pkg::cache_addr_u                           data_addr,
   input  logic [cache_pkg::DATA_W-1:0]                     req_wdata,
   input  logic [cache_pkg::NBYTES-1:0]                     req_wstrb,
   input  logic                                             invalidate,
   input  logic                                             fill_done,
   input  logic [cache_pkg::LINE_W-1:0]                     fill_line,
   input  logic                                             write_done,
   output logic                                             data_ack,
   output logic [cache_pkg::DATA_W-1:0]                     data_rdata,
   output logic                                             fill_req,
   output logic [cache_pkg::TAG_W+cache_pkg::INDEX_W-1:0]   fill_addr,
   output logic                                             write_req,
   output logic [cache_pkg::MEM_ADDR_W-1:0]                 write_addr,
   output logic [cache_pkg::DATA_W-1:0]                     write_wdata,
   output logic [cache_pkg::NBYTES-1:0]                     write_wstrb,
   output logic                                             read_hit,
   output logic                                             read_miss,
   output logic                                             write_hit,
   output logic                                             write_miss
);
   import cache_pkg::*;

   localparam int NLINES = 2**INDEX_W;

   localparam logic [1:0] S_IDLE  = 2'd0;
   localparam logic [1:0] S_FILL  = 2'd1;
   localparam logic [1:0] S_WRITE = 2'd2;

   logic [1:0]          state;
   logic [NLINES-1:0]   valid;
   logic [TAG_W-1:0]    tag_mem  [NLINES];
   logic [LINE_W-1:0]   line_mem [NLINES];
   logic [TAG_W-1:0]    tag;
   logic [INDEX_W-1:0]  idx;
   logic [OFFSET_W-1:0] off;
   logic                hit;
   logic                is_write;

   assign tag = data_addr.data.tag;
   assign idx = data_addr.data.index;
   assign off = data_addr.data.offset;

   assign hit      = valid[idx] && (tag_mem[idx] == tag);
   assign is_write = |req_wstrb;

   // event pulses, one per access
   assign read_hit   = data_req & ~is_write & hit;
   assign read_miss  = data_req & ~is_write & ~hit;
   assign write_hit  = data_req & is_write & hit;
   assign write_miss = data_req & is_write & ~hit;

   // back-end requests leave in the data_req cycle
   assign fill_req    = read_miss;
   assign fill_addr   = {tag, idx};
   assign write_req   = data_req & is_write;
   assign write_addr  = {tag, idx, off};
   assign write_wdata = req_wdata;
   assign write_wstrb = req_wstrb;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= S_IDLE;
         valid    <= '0;
         data_ack <= 1'b0;
      end else begin
         data_ack <= 1'b0;
         if (invalidate)
            valid <= '0;
         case (state)
            S_IDLE: begin
               if (read_hit)
                  data_ack <= 1'b1;
               else if (read_miss)
                  state <= S_FILL;
               else if (write_req)
                  state <= S_WRITE;
            end
            S_FILL: begin
               if (fill_done) begin
                  valid[idx] <= 1'b1;
                  data_ack   <= 1'b1;
                  state      <= S_IDLE;
               end
            end
            S_WRITE: begin
               // memory has the word, release the front end
               if (write_done) begin
                  data_ack <= 1'b1;
                  state    <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (read_hit)
         data_rdata <= line_mem[idx][off*DATA_W +: DATA_W];
      if (state == S_FILL && fill_done) begin
         line_mem[idx] <= fill_line;
         tag_mem[idx]  <= tag;
         data_rdata    <= fill_line[off*DATA_W +: DATA_W];
      end
      // byte merge on a write hit
      if (write_hit) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (req_wstrb[b])
               line_mem[idx][off*DATA_W + b*8 +: 8] <= req_wdata[b*8 +: 8];
         end
      end
   end

   a_fill_pending: assert property (@(posedge clk) disable iff (!arst_n)
      fill_done |-> state == S_FILL);
   a_write_pending: assert property (@(posedge clk) disable iff (!arst_n)
      write_done |-> state == S_WRITE);

endmodule

//--- rtl/cache_back_end.sv
`timescale 1ns/1ps

module cache_back_end (
   input  logic                                             clk,
   input  logic                                             arst_n,
   input  logic                                             fill_req,
   input  logic [cache_pkg::TAG_W+cache_pkg::INDEX_W-1:0]   fill_addr,
   input  logic                                             write_req,
   input  logic [cache_pkg::MEM_ADDR_W-1:0]                 write_addr,
   input  logic [cache_pkg::DATA_W-1:0]                     write_wdata,
   input  logic [cache_pkg::NBYTES-1:0]                     write_wstrb,
   input  logic                                             mem_rvalid,
   input  logic [cache_pkg::DATA_W-1:0]                     mem_rdata,
   input  logic                                             mem_bvalid,
   output logic                                             fill_done,
   output logic [cache_pkg::LINE_W-1:0]                     fill_line,
   output logic                                             write_done,
   output logic                                             write_idle,
   output logic                                             mem_valid,
   output logic [cache_pkg::MEM_ADDR_W-1:0]                 mem_addr,
   output logic                                             mem_we,
   output logic [cache_pkg::DATA_W-1:0]                     mem_wdata,
   output logic [cache_pkg::NBYTES-1:0]                     mem_wstrb
);
   import cache_pkg::*;

   logic [OFFSET_W-1:0] issue_cnt;
   logic [OFFSET_W-1:0] ret_cnt;
   logic [OFFSET_W:0]   pend_cnt;
   logic                wr_pend;
   logic                rd_beat;

   assign rd_beat    = mem_valid & ~mem_we;
   assign write_idle = ~(write_req | wr_pend);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         mem_valid  <= 1'b0;
         mem_we     <= 1'b0;
         issue_cnt  <= '0;
         ret_cnt    <= '0;
         pend_cnt   <= '0;
         wr_pend    <= 1'b0;
         fill_done  <= 1'b0;
         write_done <= 1'b0;
      end else begin
         fill_done  <= mem_rvalid && (ret_cnt == '1);
         write_done <= mem_bvalid;
         if (mem_rvalid)
            ret_cnt <= ret_cnt + 1'b1;
         if (write_req) begin
            mem_valid <= 1'b1;
            mem_we    <= 1'b1;
         end else if (fill_req) begin
            mem_valid <= 1'b1;
            mem_we    <= 1'b0;
            issue_cnt <= '0;
         end else if (rd_beat) begin
            // 4 beats back to back, last one at offset 3
            issue_cnt <= issue_cnt + 1'b1;
            mem_valid <= (issue_cnt != '1);
         end else begin
            mem_valid <= 1'b0;
         end
         if (rd_beat && !mem_rvalid)
            pend_cnt <= pend_cnt + 1'b1;
         else if (!rd_beat && mem_rvalid)
            pend_cnt <= pend_cnt - 1'b1;
         if (write_req)
            wr_pend <= 1'b1;
         else if (write_done)
            wr_pend <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (write_req) begin
         mem_addr  <= write_addr;
         mem_wdata <= write_wdata;
         mem_wstrb <= write_wstrb;
      end else if (fill_req) begin
         mem_addr <= {fill_addr, {OFFSET_W{1'b0}}};
      end else if (rd_beat) begin
         mem_addr <= mem_addr + 1'b1;
      end
      // returns arrive in beat order
      if (mem_rvalid)
         fill_line[ret_cnt*DATA_W +: DATA_W] <= mem_rdata;
   end

   a_rvalid_expected: assert property (@(posedge clk) disable iff (!arst_n)
      mem_rvalid |-> pend_cnt != '0);

endmodule

//--- rtl/cache_control.sv
`timescale 1ns/1ps

module cache_control #(
   parameter int CNT_W = 16
) (
   input  logic                              clk,
   input  logic                              arst_n,
   input  logic                              ctrl_req,
   input  logic [cache_pkg::CTRL_REG_W-1:0]  ctrl_reg,
   input  logic [cache_pkg::NBYTES-1:0]      req_wstrb,
   input  logic                              read_hit,
   input  logic                              read_miss,
   input  logic                              write_hit,
   input  logic                              write_miss,
   input  logic                              write_idle,
   output logic                              ctrl_ack,
   output logic [cache_pkg::DATA_W-1:0]      ctrl_rdata,
   output logic                              invalidate
);
   import cache_pkg::*;

   logic [CNT_W-1:0] cnt [4];
   logic [3:0]       ev;
   logic             wr;
   logic             clr;

   // bit order matches REG_READ_HIT .. REG_WRITE_MISS
   assign ev  = {write_miss, write_hit, read_miss, read_hit};
   assign wr  = ctrl_req & (|req_wstrb);
   assign clr = wr && (ctrl_reg == REG_CNT_CLEAR);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ctrl_ack   <= 1'b0;
         invalidate <= 1'b0;
         for (int i = 0; i < 4; i++)
            cnt[i] <= '0;
      end else begin
         ctrl_ack   <= ctrl_req;
         invalidate <= wr && (ctrl_reg == REG_INVALIDATE);
         for (int i = 0; i < 4; i++) begin
            // saturate at all ones
            if (clr)
               cnt[i] <= '0;
            else if (ev[i] && cnt[i] != '1)
               cnt[i] <= cnt[i] + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ctrl_req) begin
         case (ctrl_reg)
            REG_READ_HIT, REG_READ_MISS, REG_WRITE_HIT, REG_WRITE_MISS:
               ctrl_rdata <= DATA_W'(cnt[ctrl_reg[1:0]]);
            REG_WRITE_IDLE: ctrl_rdata <= DATA_W'(write_idle);
            default:        ctrl_rdata <= '0;
         endcase
      end
   end

endmodule

//--- rtl/cache_top.sv
`timescale 1ns/1ps

module cache_top #(
   parameter int CNT_W = 16
) (
   input  logic                              clk,
   input  logic                              arst_n,
   input  logic                              req,
   input  cache_pkg::cache_addr_u            addr,
   input  logic [cache_pkg::DATA_W-1:0]      wdata,
   input  logic [cache_pkg::NBYTES-1:0]      wstrb,
   input  logic                              invalidate_in,
   input  logic                              write_idle_in,
   input  logic                              mem_rvalid,
   input  logic [cache_pkg::DATA_W-1:0]      mem_rdata,
   input  logic                              mem_bvalid,
   output logic                              ack,
   output logic [cache_pkg::DATA_W-1:0]      rdata,
   output logic                              invalidate_out,
   output logic                              write_idle_out,
   output logic                              mem_valid,
   output logic [cache_pkg::MEM_ADDR_W-1:0]  mem_addr,
   output logic                              mem_we,
   output logic [cache_pkg::DATA_W-1:0]      mem_wdata,
   output logic [cache_pkg::NBYTES-1:0]      mem_wstrb
);
   import cache_pkg::*;

   // front end to cache memory and control
   logic                      data_req;
   logic                      data_ack;
   cache_addr_u               data_addr;
   logic [DATA_W-1:0]         data_rdata;
   logic                      ctrl_req;
   logic                      ctrl_ack;
   logic [CTRL_REG_W-1:0]     ctrl_reg;
   logic [DATA_W-1:0]         ctrl_rdata;
   logic [DATA_W-1:0]         req_wdata;
   logic [NBYTES-1:0]         req_wstrb;

   // cache memory to back end
   logic                      fill_req;
   logic [TAG_W+INDEX_W-1:0]  fill_addr;
   logic                      fill_done;
   logic [LINE_W-1:0]         fill_line;
   logic                      write_req;
   logic [MEM_ADDR_W-1:0]     write_addr;
   logic [DATA_W-1:0]         write_wdata;
   logic [NBYTES-1:0]         write_wstrb;
   logic                      write_done;

   logic                      read_hit;
   logic                      read_miss;
   logic                      write_hit;
   logic                      write_miss;
   logic                      write_idle;
   logic                      ctrl_invalidate;

   // chain with neighbouring caches
   assign invalidate_out = ctrl_invalidate | invalidate_in;
   assign write_idle_out = write_idle & write_idle_in;

   cache_front_end front_end (.*);

   cache_memory memory (
      .*,
      .invalidate (invalidate_out)
   );

   cache_back_end back_end (.*);

   cache_control #(
      .CNT_W (CNT_W)
   ) control (
      .*,
      .invalidate (ctrl_invalidate)
   );

endmodule

//--- verification/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;
   import cache_pkg::*;

   localparam int          MEM_WORDS  = 2048;
   localparam logic [31:0] LFSR_SEED  = 32'h2fd7;
   localparam logic [31:0] LFSR_TAPS  = 32'h80200003;
   // 61 accesses of at most 20 cycles each come to about 1220 cycles
   localparam int          MAX_CYCLES = 4000;

   logic                  clk           = 1'b0;
   logic                  arst_n        = 1'b0;
   logic                  req           = 1'b0;
   cache_addr_u           addr          = '0;
   logic [DATA_W-1:0]     wdata         = '0;
   logic [NBYTES-1:0]     wstrb         = '0;
   logic                  invalidate_in = 1'b0;
   logic                  write_idle_in = 1'b1;
   logic                  mem_rvalid    = 1'b0;
   logic [DATA_W-1:0]     mem_rdata     = '0;
   logic                  mem_bvalid    = 1'b0;
   logic                  ack;
   logic [DATA_W-1:0]     rdata;
   logic                  invalidate_out;
   logic                  write_idle_out;
   logic                  mem_valid;
   logic [MEM_ADDR_W-1:0] mem_addr;
   logic                  mem_we;
   logic [DATA_W-1:0]     mem_wdata;
   logic [NBYTES-1:0]     mem_wstrb;

   // memory model and the expected contents
   logic [31:0]           mem     [MEM_WORDS];
   logic [31:0]           ref_mem [MEM_WORDS];
   logic [2:0]            rd_vld  = '0;
   logic [MEM_ADDR_W-1:0] rd_a    [3];
   logic [1:0]            wr_vld  = '0;
   int                    cycle_cnt;
   int                    idle_low_cycles = 0;

   cache_top #(
      .CNT_W (16)
   ) UUT (.*);

   initial begin
      forever #20 clk = ~clk;
   end

   // read beats answered 3 cycles after issue
   // writes answered after 2
   always @(posedge clk) begin
      rd_vld     <= {rd_vld[1:0], arst_n & mem_valid & ~mem_we};
      rd_a[0]    <= mem_addr;
      rd_a[1]    <= rd_a[0];
      rd_a[2]    <= rd_a[1];
      mem_rvalid <= rd_vld[2];
      mem_rdata  <= mem[rd_a[2]];
      wr_vld     <= {wr_vld[0], arst_n & mem_valid & mem_we};
      mem_bvalid <= wr_vld[1];
      if (arst_n && mem_valid && mem_we) begin
         for (int b = 0; b < NBYTES; b++) begin
            if (mem_wstrb[b])
               mem[mem_addr][b*8 +: 8] <= mem_wdata[b*8 +: 8];
         end
      end
   end

   // cycles with a write in flight while the chain input is high
   always @(negedge clk) begin
      if (write_idle_in && !write_idle_out)
         idle_low_cycles <= idle_low_cycles + 1;
   end

   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < MAX_CYCLES) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("TEST FAIL");
      $fatal(1, "timeout: tests did not finish within %0d cycles", MAX_CYCLES);
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ LFSR_TAPS;
      return n;
   endfunction

   function automatic logic [31:0] byte_merge(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  strb);
      logic [31:0] m;
      m = old_w;
      for (int b = 0; b < 4; b++) begin
         if (strb[b])
            m[b*8 +: 8] = new_w[b*8 +: 8];
      end
      return m;
   endfunction

   function automatic logic [10:0] word_addr(input logic [4:0] t, input logic [3:0] i,
                                             input logic [1:0] o);
      return {t, i, o};
   endfunction

   task automatic fill_memory();
      logic [31:0] state;
      logic [31:0] w;
      state = LFSR_SEED;
      for (int i = 0; i < MEM_WORDS; i++) begin
         // one LFSR step per bit
         for (int b = 0; b < 32; b++) begin
            w[b]  = state[0];
            state = lfsr_next(state);
         end
         ref_mem[i] = w;
         mem[i] <= w;
      end
   endtask

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("Error: %s expected %h actual %h", name, exp, act);
         $display("TEST FAIL");
         $fatal(1, "value mismatch in %s", name);
      end
   endtask

   // one front-end access with its read data and the cycles from req to ack
   task automatic access(input logic [11:0] a, input logic [31:0] wd, input logic [3:0] ws,
                         output logic [31:0] rd, output int lat);
      lat = 0;
      @(posedge clk);
      req   <= 1'b1;
      addr  <= a;
      wdata <= wd;
      wstrb <= ws;
      @(posedge clk);
      req <= 1'b0;
      do begin
         @(negedge clk);
         lat++;
      end while (!ack);
      rd = rdata;
   endtask

   task automatic read_data(input logic [10:0] a, output logic [31:0] rd, output int lat);
      access({1'b0, a}, 32'h0, 4'h0, rd, lat);
   endtask

   task automatic read_check(input string name, input logic [10:0] a);
      logic [31:0] rd;
      int          lat;
      read_data(a, rd, lat);
      check(name, ref_mem[a], rd);
   endtask

   task automatic write_data(input logic [10:0] a, input logic [31:0] wd, input logic [3:0] ws);
      logic [31:0] rd;
      int          lat;
      access({1'b0, a}, wd, ws, rd, lat);
      ref_mem[a] = byte_merge(ref_mem[a], wd, ws);
   endtask

   task automatic read_reg(input logic [2:0] r, output logic [31:0] rd);
      int lat;
      access({1'b1, 8'h00, r}, 32'h0, 4'h0, rd, lat);
   endtask

   task automatic write_reg(input logic [2:0] r);
      logic [31:0] rd;
      int          lat;
      access({1'b1, 8'h00, r}, 32'h1, 4'hf, rd, lat);
   endtask

   task automatic check_counters(input string name, input logic [31:0] rh, input logic [31:0] rm,
                                 input logic [31:0] wh, input logic [31:0] wm);
      logic [31:0] rd;
      read_reg(REG_READ_HIT, rd);
      check({name, " read hits"}, rh, rd);
      read_reg(REG_READ_MISS, rd);
      check({name, " read misses"}, rm, rd);
      read_reg(REG_WRITE_HIT, rd);
      check({name, " write hits"}, wh, rd);
      read_reg(REG_WRITE_MISS, rd);
      check({name, " write misses"}, wm, rd);
   endtask

   // empty cache and zero counters
   task automatic start_test();
      write_reg(REG_INVALIDATE);
      write_reg(REG_CNT_CLEAR);
   endtask

   task automatic test_read_miss_hit();
      logic [10:0] a0;
      logic [10:0] a1;
      logic [31:0] rd;
      int          lat;
      a0 = word_addr(5'd3, 4'd2, 2'd1);
      a1 = word_addr(5'd3, 4'd2, 2'd3);
      start_test();
      read_check("read_miss_hit miss word", a0);
      read_data(a1, rd, lat);
      check("read_miss_hit hit word", ref_mem[a1], rd);
      check("read_miss_hit hit latency", 32'd2, lat);
      check_counters("read_miss_hit", 32'd1, 32'd1, 32'd0, 32'd0);
   endtask

   task automatic test_write_hit();
      logic [10:0] a;
      logic [31:0] old_w;
      logic [31:0] wd;
      logic [31:0] exp;
      logic [31:0] rd;
      int          lat;
      a  = word_addr(5'd12, 4'd5, 2'd2);
      wd = 32'hA5C3_5A3C;
      start_test();
      read_check("write_hit allocate", a);
      old_w = ref_mem[a];
      // strobes 0101 take bytes 0 and 2 from wdata
      exp = {old_w[31:24], wd[23:16], old_w[15:8], wd[7:0]};
      write_data(a, wd, 4'b0101);
      read_data(a, rd, lat);
      check("write_hit read back", exp, rd);
      check("write_hit read latency", 32'd2, lat);
      check("write_hit memory word", exp, mem[a]);
      check_counters("write_hit", 32'd1, 32'd1, 32'd1, 32'd0);
   endtask

   task automatic test_write_miss();
      logic [10:0] a;
      logic [31:0] old_w;
      logic [31:0] wd;
      logic [31:0] exp;
      logic [31:0] rd;
      int          lat;
      a     = word_addr(5'd20, 4'd9, 2'd0);
      wd    = 32'h1357_9BDF;
      old_w = ref_mem[a];
      exp   = {wd[31:16], old_w[15:0]};
      start_test();
      write_data(a, wd, 4'b1100);
      // no allocation so this read misses
      read_data(a, rd, lat);
      check("write_miss read back", exp, rd);
      check_counters("write_miss", 32'd0, 32'd1, 32'd0, 32'd1);
   endtask

   task automatic test_eviction();
      logic [10:0] x;
      logic [10:0] y;
      x = word_addr(5'd1, 4'd7, 2'd0);
      y = word_addr(5'd9, 4'd7, 2'd2);
      start_test();
      for (int i = 0; i < 3; i++) begin
         read_check("eviction first tag", x);
         read_check("eviction second tag", y);
      end
      check_counters("eviction", 32'd0, 32'd6, 32'd0, 32'd0);
   endtask

   task automatic test_invalidate();
      logic [10:0] a;
      a = word_addr(5'd17, 4'd11, 2'd1);
      start_test();
      read_check("invalidate first miss", a);
      read_check("invalidate first hit", a);
      write_reg(REG_INVALIDATE);
      read_check("invalidate miss after register", a);
      read_check("invalidate second hit", a);
      check("invalidate idle output", 32'd0, 32'(invalidate_out));
      @(posedge clk);
      invalidate_in <= 1'b1;
      @(negedge clk);
      check("invalidate chain output", 32'd1, 32'(invalidate_out));
      @(posedge clk);
      invalidate_in <= 1'b0;
      @(negedge clk);
      check("invalidate chain release", 32'd0, 32'(invalidate_out));
      read_check("invalidate miss after chain", a);
      check_counters("invalidate", 32'd2, 32'd3, 32'd0, 32'd0);
   endtask

   task automatic test_clear_and_idle();
      logic [10:0] a;
      logic [31:0] rd;
      int          n_low;
      a = word_addr(5'd6, 4'd14, 2'd3);
      start_test();
      read_check("clear_idle read", a);
      n_low = idle_low_cycles;
      write_data(a, 32'hCAFE_0042, 4'hf);
      // the chain output drops while the write is pending
      check("clear_idle busy during write", 32'd1, 32'(idle_low_cycles != n_low));
      read_reg(REG_READ_MISS, rd);
      check("clear_idle miss before clear", 32'd1, rd);
      write_reg(REG_CNT_CLEAR);
      check_counters("clear_idle", 32'd0, 32'd0, 32'd0, 32'd0);
      read_reg(REG_WRITE_IDLE, rd);
      check("clear_idle idle flag", 32'd1, rd);
      read_reg(REG_INVALIDATE, rd);
      check("clear_idle write-only register", 32'd0, rd);
      @(posedge clk);
      write_idle_in <= 1'b0;
      @(negedge clk);
      check("clear_idle chain low", 32'd0, 32'(write_idle_out));
      @(posedge clk);
      write_idle_in <= 1'b1;
      @(negedge clk);
      check("clear_idle chain high", 32'd1, 32'(write_idle_out));
   endtask

   initial begin
      fill_memory();
      repeat (3) @(posedge clk);
      arst_n <= 1'b1;
      @(posedge clk);
      test_read_miss_hit();
      test_write_hit();
      test_write_miss();
      test_eviction();
      test_invalidate();
      test_clear_and_idle();
      $display("TEST PASS");
      $finish;
   end

endmodule

//--- vlog.f
rtl/cache_pkg.sv
rtl/cache_front_end.sv
rtl/cache_memory.sv
rtl/cache_back_end.sv
rtl/cache_control.sv
rtl/cache_top.sv
verification/cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module cache_tb \
   --Mdir obj_dir -o cache_tb_sim

./obj_dir/cache_tb_sim | tee sim.log

grep -q "TEST PASS" sim.log
